//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert -Wno-fatal
TOP = bus_bridge_tb
FILELIST = project.f
BUILD_DIR = obj_dir
LOG = simulate.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "Simulation FAILED" $(LOG); then \
		echo "simulation reported failure"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- include/bus_bridge_consts.svh
/* bus bridge constants
 * bus and word widths, queue depth, credit width, memory size
 */
`ifndef BUS_BRIDGE_CONSTS_SVH
`define BUS_BRIDGE_CONSTS_SVH

// one bus transfer, also the word address width
`define BUS_WIDTH 8

`define HALVES_PER_WORD 2
`define WORD_WIDTH (`BUS_WIDTH * `HALVES_PER_WORD)

// queue entries, equal to the credits the slave starts with
`define REQUEST_FIFO_DEPTH 4
`define CREDIT_WIDTH 3 // holds 0 to REQUEST_FIFO_DEPTH

`define MEMORY_WORDS (1 << `BUS_WIDTH)

`endif

//--- project.f
+incdir+include
source/bus_bridge_pkg.sv
source/host_bus_slave.sv
source/request_fifo.sv
source/memory_bank.sv
source/bus_bridge_top.sv
sim/bus_bridge_tb.sv

//--- sim/bus_bridge_tb.sv
/* testbench for the bus bridge
 * host strobe tasks, vector file reader and memory scoreboard
 * bus_out_enable monitor and cycle count timeout
 */
`timescale 1ns/10ps
`include "bus_bridge_consts.svh"

module bus_bridge_tb;

	logic clock50;
	logic reset;
	logic enable;
	logic read;
	logic register_select;
	logic [`BUS_WIDTH-1:0] bus_in;
	logic ack;
	logic [`BUS_WIDTH-1:0] bus_out;
	logic bus_out_enable;

	logic [`WORD_WIDTH-1:0] scoreboard [`MEMORY_WORDS]; // expected memory contents
	byte op_list [$];
	logic [`BUS_WIDTH-1:0] address_list [$];
	logic [`WORD_WIDTH-1:0] word_list [$];
	logic [31:0] lcg_state;
	int cycle_count = 0;
	int cycle_limit = 0; // set once the vectors are known
	int test_count;
	int failed_tests;
	int error_count;
	logic monitor_on = 1'b0;

	bus_bridge_top dut0 (
		.clock50(clock50),
		.reset(reset),
		.enable(enable),
		.read(read),
		.register_select(register_select),
		.bus_in(bus_in),
		.ack(ack),
		.bus_out(bus_out),
		.bus_out_enable(bus_out_enable)
	);

	initial begin
		clock50 = 1'b0;
		forever #10 clock50 = ~clock50;
	end

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic idle_cycles();
		int count;
		count = 1 + int'((next_random() >> 16) % 3); // 1 to 3 cycles
		repeat (count) @(posedge clock50);
	endtask

	task automatic apply_reset();
		reset <= 1'b1;
		enable <= 1'b0;
		repeat (4) @(posedge clock50);
		reset <= 1'b0;
		@(posedge clock50);
		if (ack !== 1'b0 || bus_out_enable !== 1'b0) begin
			$display("FAILED %0t ns: ack or bus_out_enable not low after reset", $time);
			error_count++;
		end
		monitor_on = 1'b1;
	endtask

	// one four-phase strobe; data_seen is bus_out while ack was high
	task automatic run_strobe(input logic is_read, input logic is_data,
			input logic [`BUS_WIDTH-1:0] value, output logic [`BUS_WIDTH-1:0] data_seen);
		@(posedge clock50);
		read <= is_read;
		register_select <= is_data;
		bus_in <= value;
		enable <= 1'b1;
		@(posedge clock50);
		while (ack !== 1'b1)
			@(posedge clock50);
		data_seen = bus_out;
		enable <= 1'b0;
		while (ack !== 1'b0)
			@(posedge clock50);
		idle_cycles();
	endtask

	task automatic set_address(input logic [`BUS_WIDTH-1:0] address);
		logic [`BUS_WIDTH-1:0] ignored;
		run_strobe(1'b0, 1'b0, address, ignored);
	endtask

	task automatic write_word(input logic [`BUS_WIDTH-1:0] address,
			input logic [`WORD_WIDTH-1:0] word);
		logic [`BUS_WIDTH-1:0] ignored;
		set_address(address);
		run_strobe(1'b0, 1'b1, word[`WORD_WIDTH-1:`BUS_WIDTH], ignored); // high half first
		run_strobe(1'b0, 1'b1, word[`BUS_WIDTH-1:0], ignored);
	endtask

	// high half only and then a new address drops it
	task automatic write_partial(input logic [`BUS_WIDTH-1:0] address,
			input logic [`WORD_WIDTH-1:0] word);
		logic [`BUS_WIDTH-1:0] ignored;
		set_address(address);
		run_strobe(1'b0, 1'b1, word[`WORD_WIDTH-1:`BUS_WIDTH], ignored);
		set_address(address + 1'b1);
	endtask

	task automatic finish_test(input string name, input int errors_before);
		test_count++;
		if (error_count == errors_before) begin
			$display("test %0d %s: passed", test_count, name);
		end else begin
			failed_tests++;
			$display("test %0d %s: failed", test_count, name);
		end
	endtask

	task automatic check_read(input logic [`BUS_WIDTH-1:0] address,
			input logic [`WORD_WIDTH-1:0] expected, input string name);
		logic [`BUS_WIDTH-1:0] high_half;
		logic [`BUS_WIDTH-1:0] low_half;
		logic [`WORD_WIDTH-1:0] model_word;
		int errors_before;
		errors_before = error_count;
		model_word = scoreboard[address];
		set_address(address);
		run_strobe(1'b1, 1'b1, '0, high_half);
		run_strobe(1'b1, 1'b1, '0, low_half);
		if (high_half !== model_word[`WORD_WIDTH-1:`BUS_WIDTH]) begin
			$display("FAILED %0t ns: high half at 0x%h is 0x%h, expected 0x%h", $time,
				address, high_half, model_word[`WORD_WIDTH-1:`BUS_WIDTH]);
			error_count++;
		end
		if (low_half !== model_word[`BUS_WIDTH-1:0]) begin
			$display("FAILED %0t ns: low half at 0x%h is 0x%h, expected 0x%h", $time,
				address, low_half, model_word[`BUS_WIDTH-1:0]);
			error_count++;
		end
		if (expected !== model_word) begin
			$display("vector file expects 0x%h at 0x%h but the model holds 0x%h",
				expected, address, model_word);
			error_count++;
		end
		finish_test(name, errors_before);
	endtask

	task automatic load_vectors();
		int fd;
		int status;
		int fields;
		string line;
		byte op;
		logic [`BUS_WIDTH-1:0] address;
		logic [`WORD_WIDTH-1:0] word;
		fd = $fopen("sim/bus_bridge_vectors.txt", "r");
		if (fd == 0) begin
			$display("could not open the vector file sim/bus_bridge_vectors.txt");
			error_count++;
		end else begin
			while (!$feof(fd)) begin
				status = $fgets(line, fd);
				fields = 0;
				if (status > 0)
					fields = $sscanf(line, "%c %h %h", op, address, word);
				if (fields == 3 && (op == "W" || op == "R" || op == "P")) begin // comments fall out here
					op_list.push_back(op);
					address_list.push_back(address);
					word_list.push_back(word);
				end
			end
			$fclose(fd);
		end
	endtask

	// bus_out_enable must follow ack exactly on read strobes
	always @(posedge clock50) begin
		if (monitor_on && bus_out_enable !== (ack && read)) begin
			$display("FAILED %0t ns: bus_out_enable %b with ack %b and read %b", $time,
				bus_out_enable, ack, read);
			error_count++;
		end
	end

	always @(posedge clock50) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			$display("run timed out after %0d cycles waiting for ack", cycle_count);
			$display("Simulation FAILED");
			$finish;
		end
	end

	initial begin
		int i;
		int n;
		int errors_before;
		logic [31:0] random_word;
		logic [`BUS_WIDTH-1:0] address;
		reset = 1'b1;
		enable = 1'b0;
		read = 1'b0;
		register_select = 1'b0;
		bus_in = '0;
		lcg_state = 32'h04a167f8;
		test_count = 0;
		failed_tests = 0;
		error_count = 0;
		for (i = 0; i < `MEMORY_WORDS; i++)
			scoreboard[i] = '0;
		load_vectors();
		cycle_limit = op_list.size() * 60 + 600;
		apply_reset();
		// bank still clearing here so the first read waits it out
		for (i = 0; i < 2; i++) begin
			random_word = next_random();
			address = random_word[23:16];
			check_read(address, '0, $sformatf("read 0x%h while clearing", address));
		end
		apply_reset(); // write burst below meets a clearing bank
		for (n = 0; n < op_list.size(); n++) begin
			errors_before = error_count;
			case (op_list[n])
				"W": begin
					write_word(address_list[n], word_list[n]);
					scoreboard[address_list[n]] = word_list[n];
					finish_test($sformatf("write 0x%h to 0x%h", word_list[n], address_list[n]),
						errors_before);
				end
				"R": check_read(address_list[n], word_list[n],
					$sformatf("read 0x%h", address_list[n]));
				"P": begin
					write_partial(address_list[n], word_list[n]); // model unchanged
					finish_test($sformatf("partial write to 0x%h", address_list[n]),
						errors_before);
				end
				default: begin
					$display("vector %0d has an unknown operation", n);
					error_count++;
				end
			endcase
		end
		$display("%0d tests run, %0d failed, %0d errors", test_count, failed_tests,
			error_count);
		if (error_count == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

//--- sim/bus_bridge_vectors.txt
# op address word: W writes the word, R reads and expects the word
# P sends the high half of the word only, then strobes the next address
W 10 a5c3
W 11 1234
W 12 beef
W 13 0f0f
W 14 7e81
W 15 c001
R 10 a5c3
R 15 c001
R 12 beef
W 20 5a5a
R 20 5a5a
W 20 6b6b
R 20 6b6b
P 20 ffff
R 20 6b6b
W 21 3c3c
R 21 3c3c
P 30 1111
R 30 0000
R 13 0f0f
W ff 8001
R ff 8001
R 11 1234
R 14 7e81

//--- source/bus_bridge_pkg.sv
/* bus bridge package
 * data word union, seen whole or as two bus halves
 * memory request carried from bus slave through queue to memory bank
 */
`include "bus_bridge_consts.svh"

package bus_bridge_pkg;

	// one stored word; the slave fills it a half at a time
	typedef union packed {
		logic [`WORD_WIDTH-1:0] word;
		struct packed {
			logic [`BUS_WIDTH-1:0] high; // sent first
			logic [`BUS_WIDTH-1:0] low;
		} halves;
	} data_word_u;

	// 25 bit queue entry
	typedef struct packed {
		logic is_read;
		logic [`BUS_WIDTH-1:0] address;
		data_word_u data; // unused on reads
	} request_t;

endpackage

//--- source/bus_bridge_top.sv
/* bus bridge top level
 * host bus slave, request queue and memory bank
 */
`timescale 1ns/10ps
`include "bus_bridge_consts.svh"

module bus_bridge_top (
	input logic clock50,
	input logic reset,
	input logic enable,
	input logic read,
	input logic register_select,
	input logic [`BUS_WIDTH-1:0] bus_in,
	output logic ack,
	output logic [`BUS_WIDTH-1:0] bus_out,
	output logic bus_out_enable
);
	import bus_bridge_pkg::*;

	logic push_valid;
	request_t push_request;
	logic credit_return;
	logic pop_valid;
	request_t pop_request;
	logic pop;
	logic read_response_valid;
	data_word_u read_response_data;

	host_bus_slave slave0 (
		.clock50(clock50),
		.reset(reset),
		.enable(enable),
		.read(read),
		.register_select(register_select),
		.bus_in(bus_in),
		.credit_return(credit_return),
		.read_response_valid(read_response_valid),
		.read_response_data(read_response_data),
		.ack(ack),
		.bus_out(bus_out),
		.bus_out_enable(bus_out_enable),
		.push_valid(push_valid),
		.push_request(push_request)
	);

	request_fifo fifo0 (
		.clock50(clock50),
		.reset(reset),
		.push_valid(push_valid),
		.push_request(push_request),
		.pop(pop),
		.pop_valid(pop_valid),
		.pop_request(pop_request),
		.credit_return(credit_return)
	);

	memory_bank bank0 (
		.clock50(clock50),
		.reset(reset),
		.pop_valid(pop_valid),
		.pop_request(pop_request),
		.pop(pop),
		.read_response_valid(read_response_valid),
		.read_response_data(read_response_data)
	);

endmodule

//--- source/host_bus_slave.sv
/* host bus slave
 * four-phase strobe handshake on enable and ack
 * assembles write words from two halves, issues requests under credit
 * and serves read words back as two halves
 */
`timescale 1ns/10ps
`include "bus_bridge_consts.svh"

module host_bus_slave (
	input logic clock50,
	input logic reset,
	input logic enable,
	input logic read, // 0 write, 1 read
	input logic register_select, // 0 address, 1 data
	input logic [`BUS_WIDTH-1:0] bus_in,
	input logic credit_return,
	input logic read_response_valid,
	input bus_bridge_pkg::data_word_u read_response_data,
	output logic ack,
	output logic [`BUS_WIDTH-1:0] bus_out,
	output logic bus_out_enable,
	output logic push_valid,
	output bus_bridge_pkg::request_t push_request
);
	import bus_bridge_pkg::*;

	localparam logic [2:0] state_idle = 3'd0;
	localparam logic [2:0] state_issue = 3'd1; // waiting for a credit
	localparam logic [2:0] state_write_done = 3'd2;
	localparam logic [2:0] state_wait_response = 3'd3;
	localparam logic [2:0] state_hold = 3'd4; // ack high until enable drops
	localparam logic [`CREDIT_WIDTH-1:0] full_credit = `CREDIT_WIDTH'(`REQUEST_FIFO_DEPTH);

	logic [2:0] state;
	logic [`BUS_WIDTH-1:0] address;
	logic write_low_half;
	logic read_low_half;
	logic issue_is_read;
	data_word_u assembly_word;
	data_word_u read_word;
	logic [`CREDIT_WIDTH-1:0] credit_count;
	logic strobe_start;
	logic take_write_half;
	logic issue_fire;
	logic response_taken;
	logic second_read;

	assign strobe_start = (state == state_idle) && enable;
	assign take_write_half = strobe_start && !read && register_select;
	assign issue_fire = (state == state_issue) && (credit_count != '0);
	assign response_taken = (state == state_wait_response) && read_response_valid;
	assign second_read = strobe_start && read && read_low_half;

	always_ff @(posedge clock50) begin
		if (reset) begin
			state <= state_idle;
			ack <= 1'b0;
			bus_out_enable <= 1'b0;
			push_valid <= 1'b0;
			address <= '0;
			write_low_half <= 1'b0;
			read_low_half <= 1'b0;
			issue_is_read <= 1'b0;
		end else begin
			push_valid <= 1'b0;
			case (state)
				state_idle: begin
					if (enable) begin
						if (read) begin
							if (read_low_half) begin
								ack <= 1'b1; // stored word, no new request
								bus_out_enable <= 1'b1;
								read_low_half <= 1'b0;
								state <= state_hold;
							end else begin
								issue_is_read <= 1'b1;
								state <= state_issue;
							end
						end else if (!register_select) begin
							address <= bus_in;
							write_low_half <= 1'b0; // drops a half-written word
							read_low_half <= 1'b0;
							ack <= 1'b1;
							state <= state_hold;
						end else if (!write_low_half) begin
							write_low_half <= 1'b1;
							ack <= 1'b1;
							state <= state_hold;
						end else begin
							issue_is_read <= 1'b0;
							state <= state_issue;
						end
					end
				end
				state_issue: begin
					if (issue_fire) begin
						push_valid <= 1'b1;
						state <= issue_is_read ? state_wait_response : state_write_done;
					end
				end
				state_write_done: begin
					ack <= 1'b1; // cycle after the push
					write_low_half <= 1'b0;
					state <= state_hold;
				end
				state_wait_response: begin
					if (read_response_valid) begin
						ack <= 1'b1;
						bus_out_enable <= 1'b1;
						read_low_half <= 1'b1;
						state <= state_hold;
					end
				end
				state_hold: begin
					if (!enable) begin
						ack <= 1'b0;
						bus_out_enable <= 1'b0;
						state <= state_idle;
					end
				end
				default: state <= state_idle;
			endcase
		end
	end

	// word assembly, request and read data
	always_ff @(posedge clock50) begin
		if (take_write_half) begin
			if (write_low_half)
				assembly_word.halves.low <= bus_in;
			else
				assembly_word.halves.high <= bus_in;
		end
		if (issue_fire) begin
			push_request.is_read <= issue_is_read;
			push_request.address <= address;
			push_request.data <= assembly_word;
		end
		if (response_taken) begin
			read_word <= read_response_data;
			bus_out <= read_response_data.halves.high;
		end else if (second_read) begin
			bus_out <= read_word.halves.low;
		end
	end

	// one credit per queue entry; the queue hands them back on pop
	always_ff @(posedge clock50) begin
		if (reset) begin
			credit_count <= full_credit;
		end else begin
			case ({credit_return, push_valid})
				2'b10: credit_count <= credit_count + 1'b1;
				2'b01: credit_count <= credit_count - 1'b1;
				default: credit_count <= credit_count;
			endcase
		end
	end

	// the queue must return exactly one credit per entry taken
	assert_credit_bounded: assert property (@(posedge clock50) disable iff (reset)
		credit_count <= full_credit);
	assert_push_has_credit: assert property (@(posedge clock50) disable iff (reset)
		push_valid |-> credit_count != '0);

endmodule

//--- source/memory_bank.sv
/* memory bank behind the request queue
 * clears every word after reset, then runs queued writes and reads
 * read data comes back one cycle after the pop
 */
`timescale 1ns/10ps
`include "bus_bridge_consts.svh"

module memory_bank (
	input logic clock50,
	input logic reset,
	input logic pop_valid,
	input bus_bridge_pkg::request_t pop_request,
	output logic pop,
	output logic read_response_valid,
	output bus_bridge_pkg::data_word_u read_response_data
);
	import bus_bridge_pkg::*;

	data_word_u memory [`MEMORY_WORDS];
	logic [`BUS_WIDTH-1:0] clear_address;
	logic clearing;
	logic do_write;
	logic do_read;

	// busy clearing is the only stall
	assign pop = pop_valid && !clearing;
	assign do_write = pop && !pop_request.is_read;
	assign do_read = pop && pop_request.is_read;

	always_ff @(posedge clock50) begin
		if (reset) begin
			clearing <= 1'b1;
			clear_address <= '0;
			read_response_valid <= 1'b0;
		end else begin
			read_response_valid <= do_read;
			if (clearing) begin
				clear_address <= clear_address + 1'b1;
				if (&clear_address)
					clearing <= 1'b0; // last word cleared
			end
		end
	end

	always_ff @(posedge clock50) begin
		if (clearing)
			memory[clear_address].word <= '0;
		else if (do_write)
			memory[pop_request.address].word <= pop_request.data.word;
		if (do_read)
			read_response_data <= memory[pop_request.address];
	end

endmodule

//--- source/request_fifo.sv
/* request queue between bus slave and memory bank
 * circular buffer with occupancy count
 * returns one credit to the slave per pop
 */
`timescale 1ns/10ps
`include "bus_bridge_consts.svh"

module request_fifo (
	input logic clock50,
	input logic reset,
	input logic push_valid,
	input bus_bridge_pkg::request_t push_request,
	input logic pop,
	output logic pop_valid,
	output bus_bridge_pkg::request_t pop_request,
	output logic credit_return
);
	import bus_bridge_pkg::*;

	// depth is a power of two, pointers wrap on their own
	localparam int pointer_width = $clog2(`REQUEST_FIFO_DEPTH);
	localparam logic [`CREDIT_WIDTH-1:0] full_count = `CREDIT_WIDTH'(`REQUEST_FIFO_DEPTH);

	request_t entries [`REQUEST_FIFO_DEPTH];
	logic [pointer_width-1:0] write_pointer;
	logic [pointer_width-1:0] read_pointer;
	logic [`CREDIT_WIDTH-1:0] count;

	assign pop_valid = (count != '0);
	assign pop_request = entries[read_pointer]; // head entry, shown whenever not empty

	always_ff @(posedge clock50) begin
		if (reset) begin
			write_pointer <= '0;
			read_pointer <= '0;
			count <= '0;
			credit_return <= 1'b0;
		end else begin
			credit_return <= pop;
			if (push_valid)
				write_pointer <= write_pointer + 1'b1;
			if (pop)
				read_pointer <= read_pointer + 1'b1;
			case ({push_valid, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clock50) begin
		if (push_valid)
			entries[write_pointer] <= push_request;
	end

	// credit flow in the slave is what keeps these true
	assert_no_overflow: assert property (@(posedge clock50) disable iff (reset)
		push_valid |-> count != full_count);
	assert_no_underflow: assert property (@(posedge clock50) disable iff (reset)
		pop |-> count != '0);

endmodule
